// ==== sim.f ====
source/cpuPkg.sv
source/controlSequencer.sv
source/fetchUnit.sv
source/registerFile.sv
source/aluUnit.sv
source/memoryInterface.sv
source/busMux.sv
source/cpuTop.sv
testbench/cpuTb.sv

// ==== testbench/cpuTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

        localparam int memDepth    = 512;
        localparam int dataBase    = 256;  // programs stay below this address
        localparam int runLimit    = 4000;
        localparam int programRuns = 20;

        logic        Clock = 1'b0;
        logic        arstN;
        logic        start;
        logic        hostWrite;
        logic [8:0]  hostAddress;
        logic [31:0] hostWriteData;
        logic        busy;
        logic [31:0] hostReadData;
        logic [31:0] outPort;

        logic [31:0] lfsrState = 32'h9612;
        logic [31:0] modelRegs [16];
        logic [31:0] modelMem [memDepth];
        logic [31:0] modelOut;
        logic [31:0] progWords [$];

        cpuTop #(.memDepth(memDepth), .pcStart(32'd0)) i_cpuTop (
                .Clock, .arstN, .start, .hostWrite, .hostAddress, .hostWriteData,
                .busy, .hostReadData, .outPort
        );

        always #20 Clock = ~Clock;

        // Fibonacci LFSR with taps 32, 22, 2 and 1
        function automatic logic [31:0] randomBits(input int count);
                logic [31:0] value;
                logic        feedback;
                value = '0;
                for (int i = 0; i < count; i++) begin
                        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
                        lfsrState = {lfsrState[30:0], feedback};
                        value     = {value[30:0], feedback};
                end
                return value;
        endfunction

        task automatic stopOnFailure();
                $display("Test failures found");
                $fatal(1);
        endtask

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("ERROR at %0d ns: %s expected %h, got %h",
                                 $time, name, expected, actual);
                        stopOnFailure();
                end
        endtask

        function automatic logic [31:0] signExtend(input logic [18:0] c);
                return {{13{c[18]}}, c};
        endfunction

        function automatic logic [31:0] encode(input opcodeT op, input logic [3:0] ra,
                                               input logic [3:0] rb, input logic [18:0] low);
                return {op, ra, rb, low};
        endfunction

        // R0 counts as zero only where it serves as the address base
        function automatic logic [31:0] baseOf(input logic [3:0] rb);
                return (rb == 4'd0) ? 32'd0 : modelRegs[rb];
        endfunction

        task automatic emitLdi(input logic [3:0] ra, input logic [3:0] rb, input logic [18:0] c);
                modelRegs[ra] = baseOf(rb) + signExtend(c);
                progWords.push_back(encode(ldi, ra, rb, c));
        endtask

        task automatic emitRegOp(input opcodeT op, input logic [3:0] ra, input logic [3:0] rb,
                                 input logic [3:0] rc);
                logic [31:0] result;
                case (op)
                        sub:     result = modelRegs[rb] - modelRegs[rc];
                        andOp:   result = modelRegs[rb] & modelRegs[rc];
                        orOp:    result = modelRegs[rb] | modelRegs[rc];
                        default: result = modelRegs[rb] + modelRegs[rc];
                endcase
                modelRegs[ra] = result;
                progWords.push_back(encode(op, ra, rb, {rc, 15'd0}));
        endtask

        // the low nine bits of C are solved so that Rb + C lands on target
        task automatic emitMemOp(input opcodeT op, input logic [3:0] ra, input logic [3:0] rb,
                                 input logic [8:0] target);
                logic [31:0] base;
                logic [31:0] sum;
                logic [9:0]  high;
                logic [18:0] c;
                logic [8:0]  address;
                base    = baseOf(rb);
                high    = 10'(randomBits(10));
                c       = {high, 9'(target - base[8:0])};
                sum     = base + signExtend(c);
                address = sum[8:0];  // RAM uses the low MAR bits
                if (op == st)
                        modelMem[address] = modelRegs[ra];
                else
                        modelRegs[ra] = modelMem[address];
                progWords.push_back(encode(op, ra, rb, c));
        endtask

        task automatic emitOut(input logic [3:0] ra);
                modelOut = modelRegs[ra];
                progWords.push_back(encode(outOp, ra, 4'd0, 19'd0));
        endtask

        task automatic buildProgram(input int bodyLength);
                logic [3:0] ra;
                logic [3:0] rb;
                logic [3:0] rc;
                logic [2:0] kind;
                logic [8:0] target;
                progWords.delete();
                // even registers get constants, odd ones full words from the data area
                for (int r = 0; r < 16; r++) begin
                        if (r % 2 == 0)
                                emitLdi(4'(r), 4'd0, 19'(randomBits(19)));
                        else
                                emitMemOp(ld, 4'(r), 4'd0, 9'(dataBase + randomBits(8)));
                end
                for (int i = 0; i < bodyLength; i++) begin
                        ra     = 4'(randomBits(4));
                        rb     = 4'(randomBits(4));
                        rc     = 4'(randomBits(4));
                        kind   = 3'(randomBits(3));
                        target = 9'(dataBase + randomBits(8));
                        case (kind)
                                3'd0:    emitLdi(ra, rb, 19'(randomBits(19)));
                                3'd1:    emitRegOp(add, ra, rb, rc);
                                3'd2:    emitRegOp(sub, ra, rb, rc);
                                3'd3:    emitRegOp(andOp, ra, rb, rc);
                                3'd4:    emitRegOp(orOp, ra, rb, rc);
                                3'd5:    emitMemOp(st, ra, rb, target);
                                3'd6:    emitMemOp(ld, ra, rb, target);
                                default: emitOut(ra);
                        endcase
                end
                target = 9'(dataBase + randomBits(8));
                emitMemOp(st, 4'(randomBits(4)), 4'(randomBits(4)), target);
                emitMemOp(ld, 4'(randomBits(4)), 4'(randomBits(4)), target);  // round trip
                for (int r = 0; r < 16; r++)
                        emitMemOp(st, 4'(r), 4'd0, 9'(dataBase + r));
                emitOut(4'(randomBits(4)));
                progWords.push_back(encode(halt, 4'd0, 4'd0, 19'd0));
        endtask

        task automatic hostStore(input logic [8:0] address, input logic [31:0] data);
                hostWrite     = 1'b1;
                hostAddress   = address;
                hostWriteData = data;
                @(negedge Clock);
                hostWrite = 1'b0;
        endtask

        // read data is one cycle behind the address, so one word per cycle
        task automatic checkMemory(input int first, input int last);
                hostAddress = 9'(first);
                for (int a = first; a <= last; a++) begin
                        @(negedge Clock);
                        checkValue($sformatf("hostReadData[%0d]", a), modelMem[a], hostReadData);
                        hostAddress = 9'(a + 1);
                end
        endtask

        task automatic runProgram();
                int cycles;
                for (int i = 0; i < progWords.size(); i++) begin
                        modelMem[i] = progWords[i];
                        hostStore(9'(i), progWords[i]);
                end
                start = 1'b1;
                @(negedge Clock);
                start = 1'b0;
                checkValue("busy", 32'd1, 32'(busy));
                cycles = 0;
                while (busy !== 1'b0 && cycles < runLimit) begin
                        @(negedge Clock);
                        cycles++;
                end
                if (busy !== 1'b0) begin
                        $display("the processor never finished its program within %0d cycles",
                                 runLimit);
                        stopOnFailure();
                end
        endtask

        initial begin
                arstN         = 1'b0;
                start         = 1'b0;
                hostWrite     = 1'b0;
                hostAddress   = '0;
                hostWriteData = '0;
                modelOut      = '0;
                repeat (5) @(negedge Clock);
                arstN = 1'b1;
                checkValue("busy", 32'd0, 32'(busy));
                checkValue("outPort", 32'd0, outPort);
                for (int a = dataBase; a < memDepth; a++) begin
                        modelMem[a] = randomBits(32);
                        hostStore(9'(a), modelMem[a]);
                end
                checkMemory(dataBase, memDepth - 1);
                for (int run = 0; run < programRuns; run++) begin
                        buildProgram(8 + randomBits(4));
                        runProgram();
                        checkValue("outPort", modelOut, outPort);
                        checkMemory(dataBase, memDepth - 1);
                end
                $display("All tests passed!");
                $finish;
        end

endmodule

`default_nettype wire

// ==== source/cpuTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuTop import cpuPkg::*; #(
        parameter  int                   memDepth  = 512,
        parameter  logic [dataWidth-1:0] pcStart   = '0,
        localparam int                   addrWidth = $clog2(memDepth)
) (
        input  logic                 Clock,
        input  logic                 arstN,
        input  logic                 start,
        input  logic                 hostWrite,
        input  logic [addrWidth-1:0] hostAddress,
        input  logic [dataWidth-1:0] hostWriteData,
        output logic                 busy,
        output logic [dataWidth-1:0] hostReadData,
        output logic [dataWidth-1:0] outPort
);

        logic [dataWidth-1:0] busData;
        logic [dataWidth-1:0] pcValue;
        logic [dataWidth-1:0] cValue;
        logic [dataWidth-1:0] regData;
        logic [dataWidth-1:0] zValue;
        logic [dataWidth-1:0] mdrValue;
        instrWord             irWord;
        aluOpT                aluOp;
        logic                 pcOut, mdrOut, zOut, regOut, cOut;
        logic                 marIn, mdrIn, irIn, yIn, zIn, pcIn, regIn, outIn;
        logic                 incPc, memRead, memWrite, gra, grb, grc, baOut;

        controlSequencer i_controlSequencer (
                .Clock, .arstN, .start, .irWord, .busy,
                .pcOut, .mdrOut, .zOut, .regOut, .cOut,
                .marIn, .mdrIn, .irIn, .yIn, .zIn, .pcIn, .regIn, .outIn,
                .incPc, .memRead, .memWrite, .gra, .grb, .grc, .baOut, .aluOp
        );

        fetchUnit #(.pcStart(pcStart)) i_fetchUnit (
                .Clock, .arstN, .busData, .pcIn, .irIn, .incPc, .pcValue, .irWord, .cValue
        );

        registerFile i_registerFile (
                .Clock, .arstN, .busData, .irWord, .gra, .grb, .grc, .baOut,
                .regIn, .outIn, .regData, .outPort
        );

        aluUnit i_aluUnit (
                .Clock, .arstN, .busData, .yIn, .zIn, .aluOp, .zValue
        );

        memoryInterface #(.memDepth(memDepth)) i_memoryInterface (
                .Clock, .arstN, .busData, .marIn, .mdrIn, .memRead, .memWrite, .busy,
                .hostWrite, .hostAddress, .hostWriteData, .mdrValue, .hostReadData
        );

        busMux i_busMux (
                .pcOut, .mdrOut, .zOut, .regOut, .cOut,
                .pcValue, .mdrValue, .zValue, .regData, .cValue, .busData
        );

endmodule

`default_nettype wire

// ==== source/busMux.sv ====
`timescale 1ns/10ps
`default_nettype none

module busMux import cpuPkg::*; (
        input  logic                 pcOut,
        input  logic                 mdrOut,
        input  logic                 zOut,
        input  logic                 regOut,
        input  logic                 cOut,
        input  logic [dataWidth-1:0] pcValue,
        input  logic [dataWidth-1:0] mdrValue,
        input  logic [dataWidth-1:0] zValue,
        input  logic [dataWidth-1:0] regData,
        input  logic [dataWidth-1:0] cValue,
        output logic [dataWidth-1:0] busData
);

        localparam logic [2:0] selNone = 3'd0;
        localparam logic [2:0] selPc   = 3'd1;
        localparam logic [2:0] selMdr  = 3'd2;
        localparam logic [2:0] selZ    = 3'd3;
        localparam logic [2:0] selReg  = 3'd4;
        localparam logic [2:0] selC    = 3'd5;

        logic [2:0] sourceSel;

        // the sequencer raises at most one out strobe, so the order here is arbitrary
        always_comb begin
                if (pcOut)
                        sourceSel = selPc;
                else if (mdrOut)
                        sourceSel = selMdr;
                else if (zOut)
                        sourceSel = selZ;
                else if (regOut)
                        sourceSel = selReg;
                else if (cOut)
                        sourceSel = selC;
                else
                        sourceSel = selNone;
        end

        always_comb begin
                case (sourceSel)
                        selPc:   busData = pcValue;
                        selMdr:  busData = mdrValue;
                        selZ:    busData = zValue;
                        selReg:  busData = regData;
                        selC:    busData = cValue;
                        default: busData = '0;  // idle bus
                endcase
        end

endmodule

`default_nettype wire

// ==== source/memoryInterface.sv ====
`timescale 1ns/10ps
`default_nettype none

module memoryInterface import cpuPkg::*; #(
        parameter  int memDepth  = 512,
        localparam int addrWidth = $clog2(memDepth)
) (
        input  logic                 Clock,
        input  logic                 arstN,
        input  logic [dataWidth-1:0] busData,
        input  logic                 marIn,
        input  logic                 mdrIn,
        input  logic                 memRead,
        input  logic                 memWrite,
        input  logic                 busy,
        input  logic                 hostWrite,
        input  logic [addrWidth-1:0] hostAddress,
        input  logic [dataWidth-1:0] hostWriteData,
        output logic [dataWidth-1:0] mdrValue,
        output logic [dataWidth-1:0] hostReadData
);

        logic [dataWidth-1:0] ram [memDepth];
        logic [dataWidth-1:0] marValue;
        logic [addrWidth-1:0] wordAddress;

        assign wordAddress = marValue[addrWidth-1:0];  // upper MAR bits are ignored

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        marValue <= '0;
                        mdrValue <= '0;
                end else begin
                        if (marIn)
                                marValue <= busData;
                        if (memRead)
                                mdrValue <= ram[wordAddress];
                        else if (mdrIn)
                                mdrValue <= busData;
                end
        end

        // the host owns the write port only while the processor is idle
        always_ff @(posedge Clock) begin
                if (busy && memWrite)
                        ram[wordAddress] <= mdrValue;
                else if (!busy && hostWrite)
                        ram[hostAddress] <= hostWriteData;
                hostReadData <= ram[hostAddress];
        end

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluUnit import cpuPkg::*; (
        input  logic                 Clock,
        input  logic                 arstN,
        input  logic [dataWidth-1:0] busData,
        input  logic                 yIn,
        input  logic                 zIn,
        input  aluOpT                aluOp,
        output logic [dataWidth-1:0] zValue
);

        logic [dataWidth-1:0] yValue;
        logic [dataWidth-1:0] aluResult;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN)
                        yValue <= '0;
                else if (yIn)
                        yValue <= busData;
        end

        always_comb begin
                case (aluOp)
                        aluSub:  aluResult = yValue - busData;  // Y holds the left operand
                        aluAnd:  aluResult = yValue & busData;
                        aluOr:   aluResult = yValue | busData;
                        default: aluResult = yValue + busData;
                endcase
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN)
                        zValue <= '0;
                else if (zIn)
                        zValue <= aluResult;
        end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module registerFile import cpuPkg::*; (
        input  logic                 Clock,
        input  logic                 arstN,
        input  logic [dataWidth-1:0] busData,
        input  instrWord             irWord,
        input  logic                 gra,
        input  logic                 grb,
        input  logic                 grc,
        input  logic                 baOut,
        input  logic                 regIn,
        input  logic                 outIn,
        output logic [dataWidth-1:0] regData,
        output logic [dataWidth-1:0] outPort
);

        logic [dataWidth-1:0] regs [16];
        logic [3:0]           regSel;

        always_comb begin
                if (gra)
                        regSel = irWord.regForm.ra;
                else if (grb)
                        regSel = irWord.regForm.rb;
                else if (grc)
                        regSel = irWord.regForm.rc;
                else
                        regSel = 4'd0;
        end

        always_ff @(posedge Clock) begin
                if (regIn)
                        regs[regSel] <= busData;
        end

        // R0 as a base reads as zero so that ldi can load a plain constant
        assign regData = (baOut && regSel == 4'd0) ? '0 : regs[regSel];

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN)
                        outPort <= '0;
                else if (outIn)
                        outPort <= busData;
        end

endmodule

`default_nettype wire

// ==== source/fetchUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetchUnit import cpuPkg::*; #(
        parameter logic [dataWidth-1:0] pcStart = '0
) (
        input  logic                 Clock,
        input  logic                 arstN,
        input  logic [dataWidth-1:0] busData,
        input  logic                 pcIn,
        input  logic                 irIn,
        input  logic                 incPc,
        output logic [dataWidth-1:0] pcValue,
        output instrWord             irWord,
        output logic [dataWidth-1:0] cValue
);

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        pcValue <= '0;
                end else if (pcIn) begin
                        pcValue <= pcStart;
                end else if (incPc) begin
                        pcValue <= pcValue + 1'b1;
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN)
                        irWord <= '0;
                else if (irIn)
                        irWord <= busData;
        end

        // the constant is 19 bits wide and signed
        assign cValue = {{(dataWidth - 19){irWord.immForm.c[18]}}, irWord.immForm.c};

endmodule

`default_nettype wire

// ==== source/controlSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlSequencer import cpuPkg::*; (
        input  logic     Clock,
        input  logic     arstN,
        input  logic     start,
        input  instrWord irWord,
        output logic     busy,
        output logic     pcOut,
        output logic     mdrOut,
        output logic     zOut,
        output logic     regOut,
        output logic     cOut,
        output logic     marIn,
        output logic     mdrIn,
        output logic     irIn,
        output logic     yIn,
        output logic     zIn,
        output logic     pcIn,
        output logic     regIn,
        output logic     outIn,
        output logic     incPc,
        output logic     memRead,
        output logic     memWrite,
        output logic     gra,
        output logic     grb,
        output logic     grc,
        output logic     baOut,
        output aluOpT    aluOp
);

        logic [2:0] tState;
        logic [2:0] lastStep;
        opcodeT     opcode;
        logic       isAddrOp;   // ld, ldi and st all form Rb + C first
        logic       isAluOp;

        assign opcode   = irWord.regForm.opcode;
        assign isAddrOp = (opcode == ld) || (opcode == ldi) || (opcode == st);
        assign isAluOp  = (opcode == add) || (opcode == sub) || (opcode == andOp)
                          || (opcode == orOp);

        always_comb begin
                if (opcode == ld || opcode == st)
                        lastStep = 3'd7;
                else if (isAddrOp || isAluOp)
                        lastStep = 3'd5;
                else
                        lastStep = 3'd3;  // out, halt and unknown codes take one step
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        busy   <= 1'b0;
                        tState <= 3'd0;
                end else if (!busy) begin
                        busy   <= start;
                        tState <= 3'd0;
                end else if (tState == 3'd3 && opcode == halt) begin
                        busy   <= 1'b0;
                        tState <= 3'd0;
                end else if (tState == lastStep) begin
                        tState <= 3'd0;
                end else begin
                        tState <= tState + 3'd1;
                end
        end

        always_comb begin
                case (opcode)
                        sub:     aluOp = aluSub;
                        andOp:   aluOp = aluAnd;
                        orOp:    aluOp = aluOr;
                        default: aluOp = aluAdd;
                endcase
        end

        always_comb begin
                {pcOut, mdrOut, zOut, regOut, cOut} = '0;
                {marIn, mdrIn, irIn, yIn, zIn, regIn, outIn} = '0;
                {incPc, memRead, memWrite, gra, grb, grc, baOut} = '0;
                pcIn = start && !busy;  // PC takes pcStart on the start edge
                if (busy) begin
                        case (tState)
                                3'd0: begin
                                        pcOut = 1'b1;
                                        marIn = 1'b1;
                                        incPc = 1'b1;
                                end
                                3'd1: memRead = 1'b1;
                                3'd2: begin
                                        mdrOut = 1'b1;
                                        irIn   = 1'b1;
                                end
                                3'd3: begin
                                        if (opcode == outOp) begin
                                                gra    = 1'b1;
                                                regOut = 1'b1;
                                                outIn  = 1'b1;
                                        end else if (isAddrOp || isAluOp) begin
                                                grb    = 1'b1;
                                                regOut = 1'b1;
                                                yIn    = 1'b1;
                                                baOut  = isAddrOp;
                                        end
                                end
                                3'd4: begin
                                        zIn    = 1'b1;
                                        cOut   = isAddrOp;
                                        grc    = isAluOp;
                                        regOut = isAluOp;
                                end
                                3'd5: begin
                                        zOut = 1'b1;
                                        if (opcode == ld || opcode == st) begin
                                                marIn = 1'b1;
                                        end else begin
                                                gra   = 1'b1;
                                                regIn = 1'b1;
                                        end
                                end
                                3'd6: begin
                                        memRead = (opcode == ld);
                                        gra     = (opcode == st);
                                        regOut  = (opcode == st);
                                        mdrIn   = (opcode == st);
                                end
                                default: begin
                                        mdrOut   = (opcode == ld);
                                        gra      = (opcode == ld);
                                        regIn    = (opcode == ld);
                                        memWrite = (opcode == st);
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

        localparam int dataWidth = 32;  // width of the shared bus and every register

        typedef enum logic [4:0] {
                ld    = 5'd0,
                ldi   = 5'd1,
                st    = 5'd2,
                add   = 5'd3,
                sub   = 5'd4,
                andOp = 5'd5,
                orOp  = 5'd6,
                outOp = 5'd7,
                halt  = 5'd8
        } opcodeT;

        typedef enum logic [1:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr
        } aluOpT;

        // three-register form used by add, sub, and, or
        typedef struct packed {
                opcodeT      opcode;
                logic [3:0]  ra;
                logic [3:0]  rb;
                logic [3:0]  rc;
                logic [14:0] unused;
        } regFormT;

        typedef struct packed {
                opcodeT      opcode;
                logic [3:0]  ra;
                logic [3:0]  rb;
                logic [18:0] c;  // signed constant, extended in the fetch unit
        } immFormT;

        typedef union packed {
                regFormT regForm;
                immFormT immForm;
        } instrWord;

endpackage

`default_nettype wire
